// ==== verilog/cp0_params.svh ====
`ifndef CP0_PARAMS_SVH
`define CP0_PARAMS_SVH

// Register width of every CP0 register
`define CP0_DATA_W 32

// Number of external hardware interrupt lines
`define CP0_INT_W 6

// Status resets with BEV set, everything else clear
`define CP0_STATUS_RST 32'h0040_0000

// EBase resets to the start of kseg0
`define CP0_EBASE_RST 32'h8000_0000

// Boot vector base used while BEV is set
`define CP0_BEV_BASE 32'hBFC0_0200

// Vector offsets added to the base
`define CP0_OFS_GENERAL 32'h0000_0180
`define CP0_OFS_INT 32'h0000_0200

// Fixed identification and configuration read values
`define CP0_PRID_VAL 32'h0000_0000
`define CP0_CONFIG_VAL 32'h0000_0000

`endif

// ==== verilog/cp0_regs_pkg.sv ====
package cp0_regs_pkg;

    // CP0 register numbers as seen on the read and write address ports.
    // EBase is select 1 of register 15 and is given the spare code 31
    typedef enum logic [4:0] {
        CP0_ADDR_BADVADDR = 5'd8,
        CP0_ADDR_COUNT    = 5'd9,
        CP0_ADDR_COMPARE  = 5'd11,
        CP0_ADDR_STATUS   = 5'd12,
        CP0_ADDR_CAUSE    = 5'd13,
        CP0_ADDR_EPC      = 5'd14,
        CP0_ADDR_PRID     = 5'd15,
        CP0_ADDR_CONFIG   = 5'd16,
        CP0_ADDR_EBASE    = 5'd31
    } cp0_addr_e;

    typedef int unsigned bit_pos_t;

    // Status fields
    localparam bit_pos_t STATUS_BEV   = 22;
    localparam bit_pos_t STATUS_IM_HI = 15;
    localparam bit_pos_t STATUS_IM_LO = 8;
    localparam bit_pos_t STATUS_EXL   = 1;
    localparam bit_pos_t STATUS_IE    = 0;

    // Cause fields
    localparam bit_pos_t CAUSE_BD       = 31;
    localparam bit_pos_t CAUSE_IV       = 23;
    localparam bit_pos_t CAUSE_WP       = 22;
    localparam bit_pos_t CAUSE_IP_HW_HI = 15;
    localparam bit_pos_t CAUSE_IP_HW_LO = 10;
    localparam bit_pos_t CAUSE_IP_SW_HI = 9;
    localparam bit_pos_t CAUSE_IP_SW_LO = 8;
    localparam bit_pos_t CAUSE_EXC_HI   = 6;
    localparam bit_pos_t CAUSE_EXC_LO   = 2;

    // EBase exception base field, software writes only bits 29..12
    localparam bit_pos_t EBASE_BASE_HI = 29;
    localparam bit_pos_t EBASE_BASE_LO = 12;

endpackage

// ==== verilog/cp0_except_pkg.sv ====
package cp0_except_pkg;

    // Exception type code presented by the pipeline for one cycle
    typedef enum logic [31:0] {
        EXCEPT_NONE    = 32'h0000_0000,
        EXCEPT_INT     = 32'h0000_0001,
        EXCEPT_ADEL    = 32'h0000_0004,
        EXCEPT_ADES    = 32'h0000_0005,
        EXCEPT_SYS     = 32'h0000_0008,
        EXCEPT_BP      = 32'h0000_0009,
        EXCEPT_RI      = 32'h0000_000A,
        EXCEPT_OV      = 32'h0000_000C,
        EXCEPT_TR      = 32'h0000_000D,
        EXCEPT_ERET    = 32'h0000_000E,
        // Address error on instruction fetch
        EXCEPT_ADEL_IF = 32'h0000_000F
    } except_type_e;

    // Architectural ExcCode field values written into Cause
    typedef enum logic [4:0] {
        EXC_CODE_INT  = 5'd0,
        EXC_CODE_ADEL = 5'd4,
        EXC_CODE_ADES = 5'd5,
        EXC_CODE_SYS  = 5'd8,
        EXC_CODE_BP   = 5'd9,
        EXC_CODE_RI   = 5'd10,
        EXC_CODE_OV   = 5'd12,
        EXC_CODE_TR   = 5'd13
    } exc_code_e;

    // Which address is captured into BadVAddr on entry
    typedef enum logic [1:0] {
        BADV_NONE = 2'd0,
        BADV_PC   = 2'd1,
        BADV_MEM  = 2'd2
    } badv_src_e;

endpackage

// ==== verilog/cp0_exc_decode.sv ====
`timescale 1ns/1ps

module cp0_exc_decode import cp0_except_pkg::*; (
    input  except_type_e except_type_i,
    input  logic         exl_i,
    output logic         exc_take_o,
    output logic         epc_upd_o,
    output logic         bd_upd_o,
    output logic         eret_o,
    output exc_code_e    exc_code_o,
    output badv_src_e    badv_src_o,
    output logic         epc_slot_o,
    output logic         vec_int_o
);

    // Set for entries that must not overwrite EPC while EXL is already set
    logic epc_guard;

    always_comb begin
        exc_take_o = 1'b0;
        eret_o     = 1'b0;
        epc_guard  = 1'b0;
        epc_slot_o = 1'b0;
        vec_int_o  = 1'b0;
        exc_code_o = EXC_CODE_INT;
        badv_src_o = BADV_NONE;
        case (except_type_i)
            EXCEPT_INT: begin
                exc_take_o = 1'b1;
                epc_slot_o = 1'b1;
                vec_int_o  = 1'b1;
            end
            EXCEPT_ADEL, EXCEPT_ADES: begin
                exc_take_o = 1'b1;
                epc_guard  = 1'b1;
                epc_slot_o = 1'b1;
                badv_src_o = BADV_MEM;
                exc_code_o = (except_type_i == EXCEPT_ADEL) ? EXC_CODE_ADEL : EXC_CODE_ADES;
            end
            EXCEPT_SYS, EXCEPT_BP, EXCEPT_RI, EXCEPT_OV, EXCEPT_TR: begin
                exc_take_o = 1'b1;
                epc_guard  = 1'b1;
                epc_slot_o = 1'b1;
                case (except_type_i)
                    EXCEPT_SYS: exc_code_o = EXC_CODE_SYS;
                    EXCEPT_BP:  exc_code_o = EXC_CODE_BP;
                    EXCEPT_RI:  exc_code_o = EXC_CODE_RI;
                    EXCEPT_OV:  exc_code_o = EXC_CODE_OV;
                    default:    exc_code_o = EXC_CODE_TR;
                endcase
            end
            EXCEPT_ADEL_IF: begin
                // Fetch fault, EPC is the faulting PC itself and BD is kept
                exc_take_o = 1'b1;
                exc_code_o = EXC_CODE_ADEL;
                badv_src_o = BADV_PC;
            end
            EXCEPT_ERET: begin
                eret_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Nested entries keep the EPC and BD of the first exception
    assign epc_upd_o = exc_take_o && !(epc_guard && exl_i);
    assign bd_upd_o  = epc_upd_o && epc_slot_o;

endmodule

// ==== verilog/cp0_state_regs.sv ====
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_state_regs import cp0_regs_pkg::*, cp0_except_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we_i,
    input  cp0_addr_e              waddr_i,
    input  logic [`CP0_DATA_W-1:0] data_i,
    input  logic [`CP0_DATA_W-1:0] pc_i,
    input  logic                   in_delay_slot_i,
    input  logic [`CP0_DATA_W-1:0] mem_addr_i,
    input  logic [`CP0_INT_W-1:0]  int_i,
    input  logic                   exc_take_i,
    input  logic                   epc_upd_i,
    input  logic                   bd_upd_i,
    input  logic                   epc_slot_i,
    input  logic                   eret_i,
    input  exc_code_e              exc_code_i,
    input  badv_src_e              badv_src_i,
    output logic [`CP0_DATA_W-1:0] status_o,
    output logic [`CP0_DATA_W-1:0] cause_o,
    output logic [`CP0_DATA_W-1:0] epc_o,
    output logic [`CP0_DATA_W-1:0] badvaddr_o,
    output logic [`CP0_DATA_W-1:0] ebase_o,
    output logic                   exl_o
);

    logic [`CP0_DATA_W-1:0] status_q;
    logic [`CP0_DATA_W-1:0] cause_q;
    logic [`CP0_DATA_W-1:0] epc_q;
    logic [`CP0_DATA_W-1:0] badvaddr_q;
    logic [`CP0_DATA_W-1:0] ebase_q;
    logic [`CP0_DATA_W-1:0] epc_entry;

    // Back up to the branch when the faulting instruction sits in its delay slot
    assign epc_entry = (epc_slot_i && in_delay_slot_i) ? pc_i - `CP0_DATA_W'd4 : pc_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q   <= `CP0_STATUS_RST;
            cause_q    <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
            ebase_q    <= `CP0_EBASE_RST;
        end else begin
            // Hardware interrupt pending bits follow the pins
            cause_q[CAUSE_IP_HW_HI:CAUSE_IP_HW_LO] <= int_i;

            if (we_i) begin
                case (waddr_i)
                    CP0_ADDR_STATUS: begin
                        status_q[STATUS_BEV] <= data_i[STATUS_BEV];
                        status_q[STATUS_IM_HI:STATUS_IM_LO] <= data_i[STATUS_IM_HI:STATUS_IM_LO];
                        status_q[STATUS_EXL] <= data_i[STATUS_EXL];
                        status_q[STATUS_IE]  <= data_i[STATUS_IE];
                    end
                    CP0_ADDR_CAUSE: begin
                        cause_q[CAUSE_IV] <= data_i[CAUSE_IV];
                        cause_q[CAUSE_WP] <= data_i[CAUSE_WP];
                        cause_q[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO] <=
                            data_i[CAUSE_IP_SW_HI:CAUSE_IP_SW_LO];
                    end
                    CP0_ADDR_EPC: begin
                        epc_q <= data_i;
                    end
                    CP0_ADDR_EBASE: begin
                        ebase_q[EBASE_BASE_HI:EBASE_BASE_LO] <=
                            data_i[EBASE_BASE_HI:EBASE_BASE_LO];
                    end
                    default: begin
                    end
                endcase
            end

            // Entry and ERET come last so they override a same-cycle write
            if (exc_take_i) begin
                status_q[STATUS_EXL] <= 1'b1;
                cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] <= exc_code_i;
                if (epc_upd_i) begin
                    epc_q <= epc_entry;
                end
                if (bd_upd_i) begin
                    cause_q[CAUSE_BD] <= in_delay_slot_i;
                end
                case (badv_src_i)
                    BADV_PC:  badvaddr_q <= pc_i;
                    BADV_MEM: badvaddr_q <= mem_addr_i;
                    default: begin
                    end
                endcase
            end else if (eret_i) begin
                status_q[STATUS_EXL] <= 1'b0;
            end
        end
    end

    assign status_o   = status_q;
    assign cause_o    = cause_q;
    assign epc_o      = epc_q;
    assign badvaddr_o = badvaddr_q;
    assign ebase_o    = ebase_q;
    assign exl_o      = status_q[STATUS_EXL];

endmodule

// ==== verilog/cp0_timer.sv ====
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_timer import cp0_regs_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we_i,
    input  cp0_addr_e              waddr_i,
    input  logic [`CP0_DATA_W-1:0] data_i,
    output logic [`CP0_DATA_W-1:0] count_o,
    output logic [`CP0_DATA_W-1:0] compare_o,
    output logic                   timer_int_o
);

    logic [`CP0_DATA_W-1:0] count_q;
    logic [`CP0_DATA_W-1:0] compare_q;
    logic                   timer_int_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_q <= 1'b0;
        end else begin
            count_q <= count_q + `CP0_DATA_W'd1;
            // Sticky until software rewrites Compare
            // A zero Compare never matches
            if (compare_q != '0 && count_q == compare_q) begin
                timer_int_q <= 1'b1;
            end
            if (we_i && waddr_i == CP0_ADDR_COUNT) begin
                count_q <= data_i;
            end
            if (we_i && waddr_i == CP0_ADDR_COMPARE) begin
                compare_q   <= data_i;
                timer_int_q <= 1'b0;
            end
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = timer_int_q;

endmodule

// ==== verilog/cp0_read_mux.sv ====
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_read_mux import cp0_regs_pkg::*; (
    input  logic                   rst,
    input  cp0_addr_e              raddr_i,
    input  logic [`CP0_DATA_W-1:0] count_i,
    input  logic [`CP0_DATA_W-1:0] compare_i,
    input  logic [`CP0_DATA_W-1:0] status_i,
    input  logic [`CP0_DATA_W-1:0] cause_i,
    input  logic [`CP0_DATA_W-1:0] epc_i,
    input  logic [`CP0_DATA_W-1:0] badvaddr_i,
    input  logic [`CP0_DATA_W-1:0] ebase_i,
    output logic [`CP0_DATA_W-1:0] data_o
);

    always_comb begin
        if (rst) begin
            data_o = '0;
        end else begin
            case (raddr_i)
                CP0_ADDR_BADVADDR: data_o = badvaddr_i;
                CP0_ADDR_COUNT:    data_o = count_i;
                CP0_ADDR_COMPARE:  data_o = compare_i;
                CP0_ADDR_STATUS:   data_o = status_i;
                CP0_ADDR_CAUSE:    data_o = cause_i;
                CP0_ADDR_EPC:      data_o = epc_i;
                CP0_ADDR_EBASE:    data_o = ebase_i;
                // Identification registers are hardwired
                CP0_ADDR_PRID:     data_o = `CP0_PRID_VAL;
                CP0_ADDR_CONFIG:   data_o = `CP0_CONFIG_VAL;
                default:           data_o = '0;
            endcase
        end
    end

endmodule

// ==== verilog/cp0_vector_gen.sv ====
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_vector_gen import cp0_regs_pkg::*; (
    input  logic                   eret_i,
    input  logic                   vec_int_i,
    input  logic [`CP0_DATA_W-1:0] status_i,
    input  logic [`CP0_DATA_W-1:0] cause_i,
    input  logic [`CP0_DATA_W-1:0] ebase_i,
    input  logic [`CP0_DATA_W-1:0] epc_i,
    output logic [`CP0_DATA_W-1:0] exception_vector_o
);

    logic [`CP0_DATA_W-1:0] vec_base;
    logic [`CP0_DATA_W-1:0] vec_offset;

    always_comb begin
        // Boot vectors while BEV is set, else the 4 KB aligned EBase
        if (status_i[STATUS_BEV]) begin
            vec_base = `CP0_BEV_BASE;
        end else begin
            vec_base = {ebase_i[`CP0_DATA_W-1:EBASE_BASE_LO], {EBASE_BASE_LO{1'b0}}};
        end

        // Dedicated interrupt vector only when Cause IV asks for it
        if (vec_int_i && cause_i[CAUSE_IV]) begin
            vec_offset = `CP0_OFS_INT;
        end else begin
            vec_offset = `CP0_OFS_GENERAL;
        end

        if (eret_i) begin
            exception_vector_o = epc_i;
        end else begin
            exception_vector_o = vec_base + vec_offset;
        end
    end

endmodule

// ==== verilog/cp0_top.sv ====
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_top import cp0_regs_pkg::*, cp0_except_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CP0_INT_W-1:0]  int_i,
    input  logic                   we_i,
    input  cp0_addr_e              waddr_i,
    input  cp0_addr_e              raddr_i,
    input  logic [`CP0_DATA_W-1:0] data_i,
    input  except_type_e           except_type_i,
    input  logic [`CP0_DATA_W-1:0] pc_i,
    input  logic                   in_delay_slot_i,
    input  logic [`CP0_DATA_W-1:0] mem_addr_i,
    output logic [`CP0_DATA_W-1:0] data_o,
    output logic [`CP0_DATA_W-1:0] status_o,
    output logic [`CP0_DATA_W-1:0] cause_o,
    output logic [`CP0_DATA_W-1:0] epc_o,
    output logic [`CP0_DATA_W-1:0] exception_vector_o,
    output logic                   timer_int_o
);

    // Entry controls from the decoder
    logic      exc_take;
    logic      epc_upd;
    logic      bd_upd;
    logic      eret;
    exc_code_e exc_code;
    badv_src_e badv_src;
    logic      epc_slot;
    logic      vec_int;
    logic      exl;

    logic [`CP0_DATA_W-1:0] badvaddr;
    logic [`CP0_DATA_W-1:0] ebase;
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;

    cp0_exc_decode cp0_exc_decode_i (
        .except_type_i (except_type_i),
        .exl_i         (exl),
        .exc_take_o    (exc_take),
        .epc_upd_o     (epc_upd),
        .bd_upd_o      (bd_upd),
        .eret_o        (eret),
        .exc_code_o    (exc_code),
        .badv_src_o    (badv_src),
        .epc_slot_o    (epc_slot),
        .vec_int_o     (vec_int)
    );

    cp0_state_regs cp0_state_regs_i (
        .clk             (clk),
        .rst             (rst),
        .we_i            (we_i),
        .waddr_i         (waddr_i),
        .data_i          (data_i),
        .pc_i            (pc_i),
        .in_delay_slot_i (in_delay_slot_i),
        .mem_addr_i      (mem_addr_i),
        .int_i           (int_i),
        .exc_take_i      (exc_take),
        .epc_upd_i       (epc_upd),
        .bd_upd_i        (bd_upd),
        .epc_slot_i      (epc_slot),
        .eret_i          (eret),
        .exc_code_i      (exc_code),
        .badv_src_i      (badv_src),
        .status_o        (status_o),
        .cause_o         (cause_o),
        .epc_o           (epc_o),
        .badvaddr_o      (badvaddr),
        .ebase_o         (ebase),
        .exl_o           (exl)
    );

    cp0_timer cp0_timer_i (
        .clk         (clk),
        .rst         (rst),
        .we_i        (we_i),
        .waddr_i     (waddr_i),
        .data_i      (data_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_read_mux cp0_read_mux_i (
        .rst        (rst),
        .raddr_i    (raddr_i),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badvaddr_i (badvaddr),
        .ebase_i    (ebase),
        .data_o     (data_o)
    );

    cp0_vector_gen cp0_vector_gen_i (
        .eret_i             (eret),
        .vec_int_i          (vec_int),
        .status_i           (status_o),
        .cause_i            (cause_o),
        .ebase_i            (ebase),
        .epc_i              (epc_o),
        .exception_vector_o (exception_vector_o)
    );

endmodule

// ==== verif/cp0_tb.sv ====
`timescale 1ns/1ps
`include "cp0_params.svh"

module cp0_tb import cp0_regs_pkg::*, cp0_except_pkg::*; ();

    localparam int W = `CP0_DATA_W;
    localparam int TIMEOUT_CYCLES = 64;

    // Software writable bits of each register
    localparam logic [W-1:0] STATUS_WMASK = 32'h0040_FF03;
    localparam logic [W-1:0] CAUSE_WMASK  = 32'h00C0_0300;
    localparam logic [W-1:0] EBASE_WMASK  = 32'h3FFF_F000;

    logic                 clk;
    logic                 rst;
    logic [5:0]           int_i;
    logic                 we_i;
    cp0_addr_e            waddr_i;
    cp0_addr_e            raddr_i;
    logic [W-1:0]         data_i;
    except_type_e         except_type_i;
    logic [W-1:0]         pc_i;
    logic                 in_delay_slot_i;
    logic [W-1:0]         mem_addr_i;
    logic [W-1:0]         data_o;
    logic [W-1:0]         status_o;
    logic [W-1:0]         cause_o;
    logic [W-1:0]         epc_o;
    logic [W-1:0]         exception_vector_o;
    logic                 timer_int_o;

    // Shadow copy of the architectural state
    logic [W-1:0] m_status;
    logic [W-1:0] m_cause;
    logic [W-1:0] m_epc;
    logic [W-1:0] m_badv;
    logic [W-1:0] m_ebase;
    logic [W-1:0] m_count;
    logic [W-1:0] m_compare;
    logic         m_tint;
    logic         model_ready = 1'b0;
    integer       seed = 66144;

    cp0_top cp0_top_i (
        .clk                (clk),
        .rst                (rst),
        .int_i              (int_i),
        .we_i               (we_i),
        .waddr_i            (waddr_i),
        .raddr_i            (raddr_i),
        .data_i             (data_i),
        .except_type_i      (except_type_i),
        .pc_i               (pc_i),
        .in_delay_slot_i    (in_delay_slot_i),
        .mem_addr_i         (mem_addr_i),
        .data_o             (data_o),
        .status_o           (status_o),
        .cause_o            (cause_o),
        .epc_o              (epc_o),
        .exception_vector_o (exception_vector_o),
        .timer_int_o        (timer_int_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [W-1:0] next_random();
        next_random = $random(seed);
    endfunction

    function automatic cp0_addr_e pick_addr(input logic [W-1:0] r);
        case (r % 9)
            0:       pick_addr = CP0_ADDR_BADVADDR;
            1:       pick_addr = CP0_ADDR_COUNT;
            2:       pick_addr = CP0_ADDR_COMPARE;
            3:       pick_addr = CP0_ADDR_STATUS;
            4:       pick_addr = CP0_ADDR_CAUSE;
            5:       pick_addr = CP0_ADDR_EPC;
            6:       pick_addr = CP0_ADDR_PRID;
            7:       pick_addr = CP0_ADDR_CONFIG;
            default: pick_addr = CP0_ADDR_EBASE;
        endcase
    endfunction

    function automatic except_type_e pick_exception(input logic [W-1:0] r);
        case (r % 9)
            0:       pick_exception = EXCEPT_INT;
            1:       pick_exception = EXCEPT_ADEL;
            2:       pick_exception = EXCEPT_ADES;
            3:       pick_exception = EXCEPT_SYS;
            4:       pick_exception = EXCEPT_BP;
            5:       pick_exception = EXCEPT_RI;
            6:       pick_exception = EXCEPT_OV;
            7:       pick_exception = EXCEPT_TR;
            default: pick_exception = EXCEPT_ADEL_IF;
        endcase
    endfunction

    // Architectural ExcCode for each exception type
    function automatic logic [4:0] expected_code(input except_type_e t);
        case (t)
            EXCEPT_ADEL, EXCEPT_ADEL_IF: expected_code = 5'd4;
            EXCEPT_ADES: expected_code = 5'd5;
            EXCEPT_SYS:  expected_code = 5'd8;
            EXCEPT_BP:   expected_code = 5'd9;
            EXCEPT_RI:   expected_code = 5'd10;
            EXCEPT_OV:   expected_code = 5'd12;
            EXCEPT_TR:   expected_code = 5'd13;
            default:     expected_code = 5'd0;
        endcase
    endfunction

    function automatic logic [W-1:0] masked(input logic [W-1:0] old_v, input logic [W-1:0] new_v,
                                            input logic [W-1:0] mask);
        masked = (old_v & ~mask) | (new_v & mask);
    endfunction

    function automatic logic [W-1:0] expected_read(input cp0_addr_e addr);
        if (rst) begin
            expected_read = '0;
        end else begin
            case (addr)
                CP0_ADDR_BADVADDR: expected_read = m_badv;
                CP0_ADDR_COUNT:    expected_read = m_count;
                CP0_ADDR_COMPARE:  expected_read = m_compare;
                CP0_ADDR_STATUS:   expected_read = m_status;
                CP0_ADDR_CAUSE:    expected_read = m_cause;
                CP0_ADDR_EPC:      expected_read = m_epc;
                CP0_ADDR_EBASE:    expected_read = m_ebase;
                CP0_ADDR_PRID:     expected_read = `CP0_PRID_VAL;
                CP0_ADDR_CONFIG:   expected_read = `CP0_CONFIG_VAL;
                default:           expected_read = '0;
            endcase
        end
    endfunction

    function automatic logic [W-1:0] expected_vector();
        logic [W-1:0] base;
        logic [W-1:0] offset;
        if (m_status[STATUS_BEV]) begin
            base = `CP0_BEV_BASE;
        end else begin
            base = {m_ebase[31:12], 12'h000};
        end
        if (except_type_i == EXCEPT_INT && m_cause[CAUSE_IV]) begin
            offset = `CP0_OFS_INT;
        end else begin
            offset = `CP0_OFS_GENERAL;
        end
        expected_vector = (except_type_i == EXCEPT_ERET) ? m_epc : base + offset;
    endfunction

    // Next state of the shadow registers from the inputs seen at this edge
    task automatic model_step();
        logic exl_before;
        logic take;
        logic guard;
        logic slot;
        exl_before = m_status[STATUS_EXL];
        take  = except_type_i inside {EXCEPT_INT, EXCEPT_ADEL, EXCEPT_ADES, EXCEPT_SYS,
                                      EXCEPT_BP, EXCEPT_RI, EXCEPT_OV, EXCEPT_TR, EXCEPT_ADEL_IF};
        guard = !(except_type_i inside {EXCEPT_INT, EXCEPT_ADEL_IF});
        slot  = except_type_i != EXCEPT_ADEL_IF;
        if (rst) begin
            m_status  = `CP0_STATUS_RST;
            m_cause   = '0;
            m_epc     = '0;
            m_badv    = '0;
            m_ebase   = `CP0_EBASE_RST;
            m_count   = '0;
            m_compare = '0;
            m_tint    = 1'b0;
        end else begin
            if (m_compare != 0 && m_count == m_compare) begin
                m_tint = 1'b1;
            end
            m_count = m_count + 1;
            if (we_i) begin
                case (waddr_i)
                    CP0_ADDR_COUNT:  m_count = data_i;
                    CP0_ADDR_COMPARE: begin
                        m_compare = data_i;
                        m_tint = 1'b0;
                    end
                    CP0_ADDR_STATUS: m_status = masked(m_status, data_i, STATUS_WMASK);
                    CP0_ADDR_CAUSE:  m_cause = masked(m_cause, data_i, CAUSE_WMASK);
                    CP0_ADDR_EPC:    m_epc = data_i;
                    CP0_ADDR_EBASE:  m_ebase = masked(m_ebase, data_i, EBASE_WMASK);
                    default: ;
                endcase
            end
            m_cause[15:10] = int_i;
            if (take) begin
                m_status[STATUS_EXL] = 1'b1;
                m_cause[6:2] = expected_code(except_type_i);
                // Nested entry leaves EPC and BD alone
                if (!(guard && exl_before)) begin
                    m_epc = (slot && in_delay_slot_i) ? pc_i - 32'd4 : pc_i;
                    if (slot) begin
                        m_cause[CAUSE_BD] = in_delay_slot_i;
                    end
                end
                if (except_type_i == EXCEPT_ADEL_IF) begin
                    m_badv = pc_i;
                end else if (except_type_i inside {EXCEPT_ADEL, EXCEPT_ADES}) begin
                    m_badv = mem_addr_i;
                end
            end else if (except_type_i == EXCEPT_ERET) begin
                m_status[STATUS_EXL] = 1'b0;
            end
        end
        model_ready = 1'b1;
    endtask

    task automatic check_value(input string what, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("tests failed");
        $fatal(1, "wait loop ran out of cycles");
    endtask

    always @(posedge clk) begin
        model_step();
    end

    // Outputs are compared mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (model_ready) begin
            check_value("read data", data_o, expected_read(raddr_i));
            check_value("status", status_o, m_status);
            check_value("cause", cause_o, m_cause);
            check_value("epc", epc_o, m_epc);
            check_value("exception vector", exception_vector_o, expected_vector());
            check_value("timer interrupt", {31'd0, timer_int_o}, {31'd0, m_tint});
        end
    end

    task automatic drive_cycle(input logic we, input cp0_addr_e wa, input logic [W-1:0] wd,
                               input except_type_e t, input logic [W-1:0] pc, input logic ds,
                               input logic [W-1:0] ma, input cp0_addr_e ra);
        @(posedge clk);
        we_i            <= we;
        waddr_i         <= wa;
        data_i          <= wd;
        except_type_i   <= t;
        pc_i            <= pc;
        in_delay_slot_i <= ds;
        mem_addr_i      <= ma;
        raddr_i         <= ra;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_cycle(1'b0, CP0_ADDR_STATUS, '0, EXCEPT_NONE, '0, 1'b0, '0,
                        pick_addr(next_random()));
        end
    endtask

    // Write, then read the same register back in the following cycle
    task automatic write_reg(input cp0_addr_e addr, input logic [W-1:0] value);
        drive_cycle(1'b1, addr, value, EXCEPT_NONE, '0, 1'b0, '0, pick_addr(next_random()));
        drive_cycle(1'b0, addr, '0, EXCEPT_NONE, '0, 1'b0, '0, addr);
    endtask

    task automatic raise_exception(input except_type_e t, input logic [W-1:0] pc,
                                   input logic ds, input logic [W-1:0] ma);
        drive_cycle(1'b0, CP0_ADDR_STATUS, '0, t, pc, ds, ma, pick_addr(next_random()));
    endtask

    task automatic read_after_reset(input cp0_addr_e addr, input logic [W-1:0] exp);
        drive_cycle(1'b0, CP0_ADDR_STATUS, '0, EXCEPT_NONE, '0, 1'b0, '0, addr);
        @(negedge clk);
        check_value("value after reset", data_o, exp);
    endtask

    initial begin
        logic [W-1:0] r;
        logic [W-1:0] c;
        int cycles;
        rst             <= 1'b1;
        int_i           <= '0;
        we_i            <= 1'b0;
        waddr_i         <= CP0_ADDR_STATUS;
        raddr_i         <= CP0_ADDR_STATUS;
        data_i          <= '0;
        except_type_i   <= EXCEPT_NONE;
        pc_i            <= '0;
        in_delay_slot_i <= 1'b0;
        mem_addr_i      <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        read_after_reset(CP0_ADDR_STATUS, `CP0_STATUS_RST);
        read_after_reset(CP0_ADDR_EBASE, `CP0_EBASE_RST);
        read_after_reset(CP0_ADDR_PRID, `CP0_PRID_VAL);
        read_after_reset(CP0_ADDR_CONFIG, `CP0_CONFIG_VAL);
        read_after_reset(CP0_ADDR_CAUSE, '0);
        read_after_reset(CP0_ADDR_EPC, '0);
        read_after_reset(CP0_ADDR_BADVADDR, '0);
        read_after_reset(CP0_ADDR_COMPARE, '0);
        // Count advances by one at the edge that presents the read
        read_after_reset(CP0_ADDR_COUNT, m_count + 32'd1);
        read_after_reset(CP0_ADDR_COUNT, m_count + 32'd1);

        // Masked software writes
        for (int i = 0; i < 24; i++) begin
            case (i % 6)
                0:       write_reg(CP0_ADDR_STATUS, next_random());
                1:       write_reg(CP0_ADDR_CAUSE, next_random());
                2:       write_reg(CP0_ADDR_EPC, next_random());
                3:       write_reg(CP0_ADDR_EBASE, next_random());
                4:       write_reg(CP0_ADDR_COUNT, next_random());
                default: write_reg(CP0_ADDR_COMPARE, next_random());
            endcase
        end

        // Timer match a few cycles ahead of Count
        r = next_random();
        write_reg(CP0_ADDR_COUNT, {24'd0, r[7:0]});
        @(negedge clk);
        c = m_count;
        r = next_random();
        write_reg(CP0_ADDR_COMPARE, c + 32'd6 + {29'd0, r[2:0]});
        cycles = 0;
        @(negedge clk);
        while (timer_int_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            idle(1);
            @(negedge clk);
            cycles++;
        end
        if (timer_int_o !== 1'b1) begin
            report_timeout("the timer interrupt");
        end
        write_reg(CP0_ADDR_COMPARE, 32'h8000_0000 | next_random());
        @(negedge clk);
        check_value("timer after Compare write", {31'd0, timer_int_o}, 32'd0);

        // Exception entry with EXL clear and set and an occasional ERET
        write_reg(CP0_ADDR_STATUS, `CP0_STATUS_RST);
        drive_cycle(1'b1, CP0_ADDR_EPC, next_random(), EXCEPT_SYS, next_random(), 1'b0,
                    '0, CP0_ADDR_EPC);
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            raise_exception(pick_exception(next_random()), next_random(), r[4], next_random());
            if (r[5]) begin
                raise_exception(EXCEPT_ERET, '0, 1'b0, '0);
            end
        end

        // Vectors under BEV, under EBase, and the interrupt offset
        write_reg(CP0_ADDR_STATUS, `CP0_STATUS_RST);
        raise_exception(EXCEPT_SYS, next_random(), 1'b0, '0);
        write_reg(CP0_ADDR_EBASE, next_random());
        write_reg(CP0_ADDR_STATUS, 32'h0000_0000);
        raise_exception(EXCEPT_RI, next_random(), 1'b1, '0);
        write_reg(CP0_ADDR_CAUSE, 32'h0080_0000);
        raise_exception(EXCEPT_INT, next_random(), 1'b0, '0);
        write_reg(CP0_ADDR_CAUSE, 32'h0000_0000);
        raise_exception(EXCEPT_INT, next_random(), 1'b1, '0);
        raise_exception(EXCEPT_ERET, '0, 1'b0, '0);
        idle(2);

        // Hardware IP follows the pins while software IP keeps its value
        write_reg(CP0_ADDR_CAUSE, 32'h0000_0300);
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            drive_cycle(1'b0, CP0_ADDR_STATUS, '0, EXCEPT_NONE, '0, 1'b0, '0, CP0_ADDR_CAUSE);
            int_i <= r[5:0];
        end
        idle(2);

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/cp0_regs_pkg.sv
verilog/cp0_except_pkg.sv
verilog/cp0_exc_decode.sv
verilog/cp0_state_regs.sv
verilog/cp0_timer.sv
verilog/cp0_read_mux.sv
verilog/cp0_vector_gen.sv
verilog/cp0_top.sv
verif/cp0_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CP0 testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module cp0_tb -o cp0_sim \
    && ./obj_dir/cp0_sim \
    || { echo "simulation run reported failure"; exit 1; }
